/* hw/line_buffer.sv */
// ------------------------------------------------
// Ping-pong line memory between renderer and display.
// Banks swap on every line start; reads are registered.
// ------------------------------------------------
`timescale 1ns/10ps

module line_buffer #(
   parameter int h_active = 640
) (
   input  logic                         pixel_clk,
   input  logic                         reset,
   input  logic                         line_start,
   input  logic                         wr_en,
   input  logic [video_pkg::coord_w-1:0] wr_addr,
   input  video_pkg::rgb_t               wr_pixel,
   input  logic [video_pkg::coord_w-1:0] rd_addr,
   output video_pkg::rgb_t               rd_pixel
);
   import video_pkg::*;

   localparam int addr_w = $clog2(h_active);

   rgb_t mem [0:1][0:h_active-1];

   logic bank_sel;       // Back bank, written by renderer
   logic back_written;   // Back bank holds a rendered line
   logic front_valid;    // Front bank holds a rendered line
   logic rd_bank;
   logic rd_ok;

   // Swap cycle already reads the incoming front bank
   assign rd_bank = line_start ? bank_sel : ~bank_sel;
   assign rd_ok   = (line_start ? back_written : front_valid) &&
                    (rd_addr < coord_w'(h_active));

   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         bank_sel     <= 1'b0;
         back_written <= 1'b0;
         front_valid  <= 1'b0;
      end else if (line_start) begin
         bank_sel     <= ~bank_sel;
         front_valid  <= back_written;
         back_written <= 1'b0;
      end else if (wr_en) begin
         back_written <= 1'b1;
      end
   end

   // Memory array
   always_ff @(posedge pixel_clk) begin
      if (wr_en) mem[bank_sel][wr_addr[addr_w-1:0]] <= wr_pixel;
      rd_pixel <= rd_ok ? mem[rd_bank][rd_addr[addr_w-1:0]] : '0;  // Unrendered reads black
   end

endmodule

/* hw/line_renderer.sv */
// ------------------------------------------------
// Draws one line ahead into the line buffer.
// Bars and sprite are evaluated per column, one pixel per cycle.
// ------------------------------------------------
`timescale 1ns/10ps

module line_renderer #(
   parameter int h_active    = 640,
   parameter int sprite_size = 16
) (
   input  logic                         pixel_clk,
   input  logic                         reset,
   input  logic                         line_start,
   input  logic [video_pkg::coord_w-1:0] next_y,
   input  logic                         next_valid,
   input  video_pkg::video_cfg_t        cfg,
   output logic                         wr_en,
   output logic [video_pkg::coord_w-1:0] wr_addr,
   output video_pkg::rgb_t               wr_pixel
);
   import video_pkg::*;

   localparam logic [coord_w-1:0] col_last = coord_w'(h_active - 1);
   localparam logic [coord_w-1:0] bar_last = coord_w'(h_active / 8 - 1);  // Band width - 1
   localparam logic [coord_w:0]   span     = (coord_w + 1)'(sprite_size);

   render_state_e      state;
   logic [coord_w-1:0] col;        // Column being written
   logic [coord_w-1:0] row;        // Line being drawn
   logic [coord_w-1:0] bar_pos;    // Position inside the current band
   logic [2:0]         bar_idx;    // Band number 0..7

   logic [coord_w:0]   sx_end;
   logic [coord_w:0]   sy_end;
   logic               in_sprite;
   rgb_t               bar_color;

   // ------------------------------------------------
   // Column walk
   // ------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         state   <= idle;
         col     <= '0;
         row     <= '0;
         bar_pos <= '0;
         bar_idx <= '0;
      end else begin
         case (state)
            idle: if (line_start && next_valid) begin
               state   <= render;
               col     <= '0;
               row     <= next_y;               // Latch target line
               bar_pos <= '0;
               bar_idx <= '0;
            end
            render: begin
               if (col == col_last) state <= idle;   // Line done
               col <= col + 1'b1;
               if (bar_pos == bar_last) begin
                  bar_pos <= '0;
                  bar_idx <= bar_idx + 1'b1;
               end else begin
                  bar_pos <= bar_pos + 1'b1;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // ------------------------------------------------
   // Pixel colour
   // ------------------------------------------------
   always_comb begin
      bar_color.r = cfg.bar_en ? {4{bar_idx[2]}} : 4'h0;
      bar_color.g = cfg.bar_en ? {4{bar_idx[1]}} : 4'h0;
      bar_color.b = cfg.bar_en ? {4{bar_idx[0]}} : 4'h0;

      // Extra bit so the square may run past the screen edge
      sx_end    = {1'b0, cfg.sprite_x} + span;
      sy_end    = {1'b0, cfg.sprite_y} + span;
      in_sprite = cfg.sprite_en &&
                  (col >= cfg.sprite_x) && ({1'b0, col} < sx_end) &&
                  (row >= cfg.sprite_y) && ({1'b0, row} < sy_end);
   end

   assign wr_en    = (state == render);
   assign wr_addr  = col;
   assign wr_pixel = in_sprite ? cfg.sprite_color : bar_color;   // Sprite on top

endmodule

/* hw/pixel_output.sv */
// ------------------------------------------------
// Display stage with optional gray conversion.
// Sync and de follow the pixel through the same two registers.
// ------------------------------------------------
`timescale 1ns/10ps

module pixel_output (
   input  logic             pixel_clk,
   input  logic             reset,
   input  logic             gray_en,
   input  video_pkg::sync_t sync_in,
   input  video_pkg::rgb_t  rd_pixel,    // One cycle behind sync_in
   output video_pkg::rgb_t  vga_rgb,
   output logic             vga_hsync,
   output logic             vga_vsync,
   output logic             vga_de
);
   import video_pkg::*;

   localparam sync_t sync_idle = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

   sync_t      sync_d1;     // Matches buffer read
   sync_t      sync_d2;     // Matches vga_rgb
   logic [5:0] luma_sum;    // r + 2g + b, max 60
   rgb_t       pix_mix;

   always_comb begin
      luma_sum = {2'b00, rd_pixel.r} + {1'b0, rd_pixel.g, 1'b0} + {2'b00, rd_pixel.b};
      if (gray_en) begin
         pix_mix.r = luma_sum[5:2];   // Divide by 4
         pix_mix.g = luma_sum[5:2];
         pix_mix.b = luma_sum[5:2];
      end else begin
         pix_mix = rd_pixel;
      end
   end

   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         sync_d1 <= sync_idle;
         sync_d2 <= sync_idle;
         vga_rgb <= '0;
      end else begin
         sync_d1 <= sync_in;
         sync_d2 <= sync_d1;
         vga_rgb <= sync_d1.de ? pix_mix : '0;   // Black in blanking
      end
   end

   assign vga_hsync = sync_d2.hsync;
   assign vga_vsync = sync_d2.vsync;
   assign vga_de    = sync_d2.de;

endmodule

/* hw/vga_timing.sv */
// ------------------------------------------------
// VGA raster counters with active-low syncs and de.
// Also tells the renderer which line is displayed next.
// ------------------------------------------------
`timescale 1ns/10ps

module vga_timing #(
   parameter int h_active = 640,
   parameter int h_front  = 16,
   parameter int h_sync   = 96,
   parameter int h_back   = 48,
   parameter int v_active = 480,
   parameter int v_front  = 10,
   parameter int v_sync   = 2,
   parameter int v_back   = 33
) (
   input  logic                         pixel_clk,
   input  logic                         reset,
   output logic [video_pkg::coord_w-1:0] hcount,
   output video_pkg::sync_t              sync,
   output logic                         line_start,   // hcount at 0
   output logic                         frame_start,  // First cycle of vsync
   output logic [video_pkg::coord_w-1:0] next_y,
   output logic                         next_valid
);
   import video_pkg::*;

   localparam int h_total = h_active + h_front + h_sync + h_back;
   localparam int v_total = v_active + v_front + v_sync + v_back;

   // Sized compare points
   localparam logic [coord_w-1:0] h_act    = coord_w'(h_active);
   localparam logic [coord_w-1:0] h_last   = coord_w'(h_total - 1);
   localparam logic [coord_w-1:0] hs_start = coord_w'(h_active + h_front);
   localparam logic [coord_w-1:0] hs_end   = coord_w'(h_active + h_front + h_sync);
   localparam logic [coord_w-1:0] v_act    = coord_w'(v_active);
   localparam logic [coord_w-1:0] v_last   = coord_w'(v_total - 1);
   localparam logic [coord_w-1:0] vs_start = coord_w'(v_active + v_front);
   localparam logic [coord_w-1:0] vs_end   = coord_w'(v_active + v_front + v_sync);

   logic [coord_w-1:0] vcount;   // Line being displayed

   // ------------------------------------------------
   // Counters
   // ------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
      end else if (hcount == h_last) begin
         hcount <= '0;                                 // End of line
         vcount <= (vcount == v_last) ? '0 : vcount + 1'b1;
      end else begin
         hcount <= hcount + 1'b1;
      end
   end

   // ------------------------------------------------
   // Decode
   // ------------------------------------------------
   always_comb begin
      sync.hsync = !((hcount >= hs_start) && (hcount < hs_end));
      sync.vsync = !((vcount >= vs_start) && (vcount < vs_end));
      sync.de    = (hcount < h_act) && (vcount < v_act);
   end

   assign line_start  = (hcount == '0);
   assign frame_start = line_start && (vcount == vs_start);

   // Line after the current one, wrapping to 0
   assign next_y     = (vcount == v_last) ? '0 : vcount + 1'b1;
   assign next_valid = (next_y < v_act);   // Blanking lines are skipped

endmodule

/* hw/video_pkg.sv */
// ------------------------------------------------
// Shared types of the line-buffered video generator.
// Imported by every RTL block and by the testbench.
// ------------------------------------------------

package video_pkg;

   // Width of pixel and line coordinates
   localparam int coord_w = 11;

   // 4 bits per channel
   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   // Register map, one word each
   typedef enum logic [1:0] {
      reg_ctrl         = 2'd0,   // Bit 0 bars, bit 1 sprite, bit 2 gray
      reg_sprite_x     = 2'd1,
      reg_sprite_y     = 2'd2,
      reg_sprite_color = 2'd3    // Low 12 bits as rgb_t
   } reg_addr_e;

   // Settings of the frame being drawn
   typedef struct packed {
      logic               bar_en;
      logic               sprite_en;
      logic               gray_en;
      logic [coord_w-1:0] sprite_x;
      logic [coord_w-1:0] sprite_y;
      rgb_t               sprite_color;
   } video_cfg_t;

   // Syncs are active low
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic de;
   } sync_t;

   typedef enum logic {idle, render} render_state_e;

endpackage

/* hw/video_regs.sv */
// ------------------------------------------------
// Strobe-written configuration registers with a frame shadow.
// The shadow loads at the start of vertical sync.
// ------------------------------------------------
`timescale 1ns/10ps

module video_regs (
   input  logic                  pixel_clk,
   input  logic                  reset,
   input  logic                  reg_write,      // One-cycle write strobe
   input  video_pkg::reg_addr_e  reg_address,
   input  logic [15:0]           reg_writedata,
   input  logic                  frame_start,    // First cycle of vsync
   output video_pkg::video_cfg_t cfg
);
   import video_pkg::*;

   // ------------------------------------------------
   // Registers written by the host
   // ------------------------------------------------
   logic [2:0]         ctrl_q;           // gray, sprite, bar enables
   logic [coord_w-1:0] sprite_x_q;
   logic [coord_w-1:0] sprite_y_q;
   rgb_t               sprite_color_q;

   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         ctrl_q         <= '0;
         sprite_x_q     <= '0;
         sprite_y_q     <= '0;
         sprite_color_q <= '0;
      end else if (reg_write) begin
         case (reg_address)
            reg_ctrl:         ctrl_q         <= reg_writedata[2:0];
            reg_sprite_x:     sprite_x_q     <= reg_writedata[coord_w-1:0];
            reg_sprite_y:     sprite_y_q     <= reg_writedata[coord_w-1:0];
            reg_sprite_color: sprite_color_q <= reg_writedata[11:0];
            default:          ctrl_q         <= ctrl_q;
         endcase
      end
   end

   // ------------------------------------------------
   // Frame shadow, loaded once per frame
   // ------------------------------------------------
   always_ff @(posedge pixel_clk) begin
      if (reset) begin
         cfg <= '0;                           // Black screen
      end else if (frame_start) begin
         cfg.bar_en       <= ctrl_q[0];
         cfg.sprite_en    <= ctrl_q[1];
         cfg.gray_en      <= ctrl_q[2];
         cfg.sprite_x     <= sprite_x_q;
         cfg.sprite_y     <= sprite_y_q;
         cfg.sprite_color <= sprite_color_q;
      end
   end

endmodule

/* hw/video_system.sv */
// ------------------------------------------------
// Top of the video generator on a single pixel clock.
// Geometry and sprite size are set here and passed down.
// ------------------------------------------------
`timescale 1ns/10ps

module video_system #(
   parameter int h_active    = 640,
   parameter int h_front     = 16,
   parameter int h_sync      = 96,
   parameter int h_back      = 48,
   parameter int v_active    = 480,
   parameter int v_front     = 10,
   parameter int v_sync      = 2,
   parameter int v_back      = 33,
   parameter int sprite_size = 16
) (
   input  logic                 pixel_clk,
   input  logic                 reset,
   input  logic                 reg_write,
   input  video_pkg::reg_addr_e reg_address,
   input  logic [15:0]          reg_writedata,
   output video_pkg::rgb_t      vga_rgb,
   output logic                 vga_hsync,
   output logic                 vga_vsync,
   output logic                 vga_de
);
   import video_pkg::*;

   // ------------------------------------------------
   // Internal nets
   // ------------------------------------------------
   video_cfg_t         cfg;
   sync_t              sync;
   logic [coord_w-1:0] hcount;
   logic               line_start;
   logic               frame_start;
   logic [coord_w-1:0] next_y;
   logic               next_valid;
   logic               wr_en;
   logic [coord_w-1:0] wr_addr;
   rgb_t               wr_pixel;
   rgb_t               rd_pixel;

   video_regs u_video_regs (
      .pixel_clk(pixel_clk), .reset(reset), .reg_write(reg_write),
      .reg_address(reg_address), .reg_writedata(reg_writedata),
      .frame_start(frame_start), .cfg(cfg)
   );

   vga_timing #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
   ) u_vga_timing (
      .pixel_clk(pixel_clk), .reset(reset), .hcount(hcount), .sync(sync),
      .line_start(line_start), .frame_start(frame_start),
      .next_y(next_y), .next_valid(next_valid)
   );

   line_renderer #(.h_active(h_active), .sprite_size(sprite_size)) u_line_renderer (
      .pixel_clk(pixel_clk), .reset(reset), .line_start(line_start),
      .next_y(next_y), .next_valid(next_valid), .cfg(cfg),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_pixel(wr_pixel)
   );

   line_buffer #(.h_active(h_active)) u_line_buffer (
      .pixel_clk(pixel_clk), .reset(reset), .line_start(line_start),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
      .rd_addr(hcount), .rd_pixel(rd_pixel)          // Display reads at raster column
   );

   pixel_output u_pixel_output (
      .pixel_clk(pixel_clk), .reset(reset), .gray_en(cfg.gray_en),
      .sync_in(sync), .rd_pixel(rd_pixel), .vga_rgb(vga_rgb),
      .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_de(vga_de)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the video_system testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module tb_video_system \
   -f video_system.f -o sim_video_system

./obj_dir/sim_video_system > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
   echo "Simulation reported errors"
   exit 1
fi
echo "Simulation completed without errors"

/* tests/tb_video_system.sv */
// ------------------------------------------------
// Testbench for the video generator on a small raster.
// Applies a table of register settings while the checker compares pixels.
// ------------------------------------------------
`timescale 1ns/10ps

module tb_video_system;
   import video_pkg::*;

   // Small geometry, 40 x 12 raster
   localparam int h_active     = 32;
   localparam int h_front      = 2;
   localparam int h_sync       = 4;
   localparam int h_back       = 2;
   localparam int v_active     = 8;
   localparam int v_front      = 1;
   localparam int v_sync       = 2;
   localparam int v_back       = 1;
   localparam int sprite_size  = 4;
   localparam int frame_cycles = (h_active + h_front + h_sync + h_back) *
                                 (v_active + v_front + v_sync + v_back);
   localparam int wait_limit   = 2 * frame_cycles;   // Cycles per wait
   localparam int n_tests      = 8;

   typedef struct packed {
      logic [2:0]  ctrl;        // Gray, sprite, bar enables
      logic [10:0] sprite_x;
      logic [10:0] sprite_y;
      logic [11:0] color;
      logic        rnd_color;   // Colour replaced by a random one
   } stim_t;

   logic       pixel_clk;
   logic       reset;
   logic       reg_write;
   reg_addr_e  reg_address;
   logic [15:0] reg_writedata;
   rgb_t       vga_rgb;
   logic       vga_hsync;
   logic       vga_vsync;
   logic       vga_de;

   string  cur_name;               // Name handed to the checker
   string  stim_name [n_tests];
   stim_t  stim [n_tests];
   integer seed;
   int     tb_errors;
   logic   timed_out;
   int     mismatch_count;
   int     error_count;
   int     frame_count;
   int     pixel_count;

   video_system #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back),
      .sprite_size(sprite_size)
   ) DUT (
      .pixel_clk(pixel_clk), .reset(reset), .reg_write(reg_write),
      .reg_address(reg_address), .reg_writedata(reg_writedata),
      .vga_rgb(vga_rgb), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_de(vga_de)
   );

   video_checker #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .sprite_size(sprite_size)
   ) u_video_checker (
      .pixel_clk(pixel_clk), .reset(reset), .reg_write(reg_write),
      .reg_address(reg_address), .reg_writedata(reg_writedata),
      .vga_rgb(vga_rgb), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_de(vga_de),
      .test_name(cur_name), .mismatch_count(mismatch_count),
      .error_count(error_count), .frame_count(frame_count), .pixel_count(pixel_count)
   );

   always #20 pixel_clk = ~pixel_clk;   // 40 ns period

   // ------------------------------------------------
   // Stimulus table
   // ------------------------------------------------
   task automatic load_table();
      stim_name[0] = "cleared";      stim[0] = '{3'b000, 11'd0,  11'd0, 12'h000, 1'b0};
      stim_name[1] = "bars";         stim[1] = '{3'b001, 11'd0,  11'd0, 12'h000, 1'b0};
      stim_name[2] = "sprite_mid";   stim[2] = '{3'b011, 11'd10, 11'd2, 12'h000, 1'b1};
      stim_name[3] = "sprite_edge";  stim[3] = '{3'b011, 11'd30, 11'd6, 12'h000, 1'b1};
      stim_name[4] = "sprite_only";  stim[4] = '{3'b010, 11'd0,  11'd0, 12'h9c3, 1'b0};
      stim_name[5] = "gray_sprite";  stim[5] = '{3'b111, 11'd13, 11'd3, 12'h000, 1'b1};
      stim_name[6] = "gray_bars";    stim[6] = '{3'b101, 11'd5,  11'd5, 12'hfff, 1'b0};
      stim_name[7] = "all_off";      stim[7] = '{3'b000, 11'd20, 11'd1, 12'h5a7, 1'b0};
   endtask

   // Write strobe for one cycle, driven on the falling edge
   task automatic write_reg(input reg_addr_e addr, input logic [15:0] data);
      @(negedge pixel_clk);
      reg_write     = 1'b1;
      reg_address   = addr;
      reg_writedata = data;
      @(negedge pixel_clk);
      reg_write     = 1'b0;
   endtask

   task automatic wait_vsync_fall();
      int   n;
      logic prev;
      logic found;
      n     = 0;
      prev  = 1'b0;   // Ignore the level at entry
      found = 1'b0;
      while (!timed_out && !found && n < wait_limit) begin
         @(negedge pixel_clk);
         found = prev && !vga_vsync;
         prev  = vga_vsync;
         n++;
      end
      if (!timed_out && !found) begin
         $display("Timeout after %0d cycles while waiting for vsync to fall", wait_limit);
         tb_errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_de_rise();
      int   n;
      logic prev;
      logic found;
      n     = 0;
      prev  = 1'b1;   // A line already running does not count
      found = 1'b0;
      while (!timed_out && !found && n < wait_limit) begin
         @(negedge pixel_clk);
         found = !prev && vga_de;
         prev  = vga_de;
         n++;
      end
      if (!timed_out && !found) begin
         $display("Timeout after %0d cycles while waiting for de to rise", wait_limit);
         tb_errors++;
         timed_out = 1'b1;
      end
   endtask

   // Writes land on line 2 of a frame, then two frames are shown
   task automatic run_entry(input int idx);
      stim_t s;
      int    rnd;
      s = stim[idx];
      if (s.rnd_color) begin
         rnd     = $random(seed);
         s.color = rnd[11:0];
      end
      wait_vsync_fall();
      repeat (3) wait_de_rise();
      if (!timed_out) begin
         cur_name = stim_name[idx];
         $display("Applying %s: ctrl=%b x=%0d y=%0d color=%h",
                  stim_name[idx], s.ctrl, s.sprite_x, s.sprite_y, s.color);
         write_reg(reg_ctrl, {13'd0, s.ctrl});
         write_reg(reg_sprite_x, {5'd0, s.sprite_x});
         write_reg(reg_sprite_y, {5'd0, s.sprite_y});
         write_reg(reg_sprite_color, {4'd0, s.color});
         wait_vsync_fall();
         wait_vsync_fall();
      end
   endtask

   // ------------------------------------------------
   // Main sequence
   // ------------------------------------------------
   initial begin
      seed          = 32'h151b_ea56;
      pixel_clk     = 1'b0;
      reset         = 1'b1;
      reg_write     = 1'b0;
      reg_address   = reg_ctrl;
      reg_writedata = '0;
      cur_name      = "reset";
      tb_errors     = 0;
      timed_out     = 1'b0;
      load_table();

      repeat (4) @(negedge pixel_clk);   // Four reset cycles
      reset = 1'b0;

      for (int i = 0; i < n_tests; i++) begin
         if (!timed_out) run_entry(i);
      end

      if (pixel_count == 0) begin
         $display("No pixels were checked");
         tb_errors++;
      end
      $display("Errors: %0d mismatches, %0d checker errors, %0d testbench errors, %0d frames",
               mismatch_count, error_count, tb_errors, frame_count);
      if (mismatch_count + error_count + tb_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* tests/video_checker.sv */
// ------------------------------------------------
// Watches the video ports and checks every displayed pixel.
// Expected picture follows the register writes seen on the bus.
// ------------------------------------------------
`timescale 1ns/10ps

module video_checker #(
   parameter int h_active    = 32,
   parameter int h_front     = 2,
   parameter int h_sync      = 4,
   parameter int h_back      = 2,
   parameter int v_active    = 8,
   parameter int sprite_size = 4
) (
   input  logic                 pixel_clk,
   input  logic                 reset,
   input  logic                 reg_write,
   input  video_pkg::reg_addr_e reg_address,
   input  logic [15:0]          reg_writedata,
   input  video_pkg::rgb_t      vga_rgb,
   input  logic                 vga_hsync,
   input  logic                 vga_vsync,
   input  logic                 vga_de,
   input  string                test_name,        // Setting being applied
   output int                   mismatch_count,
   output int                   error_count,      // Timing and idle faults
   output int                   frame_count,
   output int                   pixel_count
);
   import video_pkg::*;

   localparam int h_total  = h_active + h_front + h_sync + h_back;
   localparam int hs_first = h_active + h_front;   // First column of hsync
   localparam int hs_last  = hs_first + h_sync;    // First column after hsync

   video_cfg_t pending;              // Registers as written
   video_cfg_t active;               // Settings of the frame on screen
   string      frame_name;
   logic       reset_seen = 1'b0;
   logic       vsync_q;
   logic       de_q;
   int         x;                    // Column within the line
   int         y;                    // Active line within the frame
   int         hpos;                 // Raster column, -1 before the first line
   logic       hs_want;
   rgb_t       want;

   // ------------------------------------------------
   // Picture model
   // ------------------------------------------------
   function automatic rgb_t expected_pixel(input video_cfg_t c, input int px, input int py);
      rgb_t p;
      int   bar;
      int   sx;
      int   sy;
      int   luma;
      p = '0;                                   // Black background
      if (c.bar_en) begin
         bar = px * 8 / h_active;
         p.r = bar[2] ? 4'hf : 4'h0;
         p.g = bar[1] ? 4'hf : 4'h0;
         p.b = bar[0] ? 4'hf : 4'h0;
      end
      sx = int'(c.sprite_x);
      sy = int'(c.sprite_y);
      if (c.sprite_en && px >= sx && px < sx + sprite_size &&
          py >= sy && py < sy + sprite_size) begin
         p = c.sprite_color;                    // Sprite on top of bars
      end
      if (c.gray_en) begin
         luma = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
         p.r  = luma[3:0];
         p.g  = luma[3:0];
         p.b  = luma[3:0];
      end
      return p;
   endfunction

   // ------------------------------------------------
   // Port monitor
   // ------------------------------------------------
   always @(posedge pixel_clk) begin
      if (reset) begin
         if (!reset_seen) begin
            mismatch_count = 0;
            error_count    = 0;
            frame_count    = 0;
            pixel_count    = 0;
         end else if (vga_de || !vga_hsync || !vga_vsync || vga_rgb != '0) begin
            error_count++;
            $display("Outputs not idle during reset: de=%b hsync=%b vsync=%b rgb=%h",
                     vga_de, vga_hsync, vga_vsync, vga_rgb);
         end
         reset_seen = 1'b1;
         pending    = '0;                       // Cleared registers, black screen
         active     = '0;
         frame_name = test_name;
         vsync_q    = 1'b1;
         de_q       = 1'b0;
         x          = 0;
         y          = 0;
         hpos       = -1;
      end else begin
         // New frame settings at vsync fall
         if (vsync_q && !vga_vsync) begin
            if (y != v_active) begin
               error_count++;
               $display("Frame %0d of %s showed %0d active lines instead of %0d",
                        frame_count, frame_name, y, v_active);
            end
            frame_count++;
            active     = pending;
            frame_name = test_name;
            y          = 0;
         end

         if (reg_write) begin
            case (reg_address)
               reg_ctrl: begin
                  pending.bar_en    = reg_writedata[0];
                  pending.sprite_en = reg_writedata[1];
                  pending.gray_en   = reg_writedata[2];
               end
               reg_sprite_x:     pending.sprite_x     = reg_writedata[10:0];
               reg_sprite_y:     pending.sprite_y     = reg_writedata[10:0];
               reg_sprite_color: pending.sprite_color = reg_writedata[11:0];
               default: ;
            endcase
         end

         if (vga_de) begin
            if (!de_q) x = 0;                   // Line begins
            want = expected_pixel(active, x, y);
            if (vga_rgb !== want) begin
               mismatch_count++;
               $display("MISMATCH %s x=%0d y=%0d expected %h actual %h",
                        frame_name, x, y, want, vga_rgb);
            end
            pixel_count++;
            x++;
         end else begin
            if (de_q) begin
               if (x != h_active) begin
                  error_count++;
                  $display("Line %0d of %s showed %0d pixels instead of %0d",
                           y, frame_name, x, h_active);
               end
               y++;
            end
            if (vga_rgb != '0) begin
               error_count++;
               $display("Colour %h driven during blanking in %s", vga_rgb, frame_name);
            end
         end

         // Horizontal sync against the raster column
         if (vga_de && !de_q) begin
            hpos = 0;
         end else if (hpos >= 0) begin
            hpos = (hpos + 1) % h_total;
         end
         if (hpos >= 0) begin
            hs_want = !(hpos >= hs_first && hpos < hs_last);   // Low in sync window
            if (vga_hsync !== hs_want) begin
               mismatch_count++;
               $display("MISMATCH %s hsync at column %0d expected %b actual %b",
                        frame_name, hpos, hs_want, vga_hsync);
            end
         end

         vsync_q = vga_vsync;
         de_q    = vga_de;
      end
   end

endmodule

/* video_system.f */
hw/video_pkg.sv
hw/video_regs.sv
hw/vga_timing.sv
hw/line_renderer.sv
hw/line_buffer.sv
hw/pixel_output.sv
hw/video_system.sv
tests/video_checker.sv
tests/tb_video_system.sv
